// ==== sgd_defines.svh ====
//##########################################################################
// SGD accelerator build parameters
// lane count, beat framing and datapath widths shared by all blocks
//##########################################################################

`ifndef SGD_DEFINES_SVH
`define SGD_DEFINES_SVH

// features and weights carried per beat
`define SGD_LANES 4

// beats per sample, at least 2
`define SGD_BEATS 4

// features, weights, label and learning rate
`define SGD_IN_W 8

// partial sum, error and updated weights
// all arithmetic wraps at this width
`define SGD_ACC_W 24

// arithmetic right shift on mu * err * x
`define SGD_SHIFT 8

`endif

// ==== sgd_pkg.sv ====
//##########################################################################
// SGD accelerator types
// scalar words, the per-beat payload and the per-beat result vector
//##########################################################################

`include "sgd_defines.svh"

package sgd_pkg;

    // one input word: feature, weight, label or mu
    typedef logic signed [`SGD_IN_W-1:0] in_word_t;

    // accumulator-width word
    typedef logic signed [`SGD_ACC_W-1:0] acc_word_t;

    // one beat of a sample, lane i sits at index i
    typedef struct packed {
        in_word_t [`SGD_LANES-1:0] feat;
        in_word_t [`SGD_LANES-1:0] wgt;
    } beat_t;

    // updated weights of one beat
    typedef acc_word_t [`SGD_LANES-1:0] result_t;

endpackage

// ==== sgd_controller.sv ====
//##########################################################################
// SGD beat controller
// frames each sample and marks its first and last beats
//##########################################################################

`timescale 1ns/100ps

`include "sgd_defines.svh"

module sgd_controller (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic first,
    output logic last,
    output logic busy
);

    localparam int CNT_W = $clog2(`SGD_BEATS);

    // index of the beat in the current cycle, valid while active
    logic [CNT_W-1:0] beat_cnt;
    logic             active;

    // a new sample may begin on the cycle right after a last beat
    assign first = start && !active;
    assign last  = active && (beat_cnt == CNT_W'(`SGD_BEATS - 1));
    assign busy  = active || first;

    always_ff @(posedge clk) begin
        if (rst) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (first) begin
            // beat 0 is the start cycle itself
            active   <= 1'b1;
            beat_cnt <= CNT_W'(1);
        end else if (last) begin
            active   <= 1'b0;
            beat_cnt <= '0;
        end else if (active) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // beats of one sample must not be cut short by a new start
    start_only_when_idle: assert property (
        @(posedge clk) disable iff (rst)
        start |-> !active
    ) else $error("start seen while a sample is in progress");

endmodule

// ==== inner_product.sv ====
//##########################################################################
// SGD stage 1, inner product
// multiplies feature/weight pairs and accumulates them across the beats
//##########################################################################

`timescale 1ns/100ps

`include "sgd_defines.svh"

module inner_product (
    input  logic              clk,
    input  logic              rst,
    input  sgd_pkg::beat_t    beat,
    input  logic              first,
    output sgd_pkg::acc_word_t sum
);

    // partial sum of the beats seen so far
    sgd_pkg::acc_word_t psum_q;
    // lane products of the current beat
    sgd_pkg::acc_word_t beat_sum;

    always_comb begin
        beat_sum = '0;
        for (int i = 0; i < `SGD_LANES; i++) begin
            // signed operands, product extended to the accumulator width
            beat_sum = beat_sum + beat.feat[i] * beat.wgt[i];
        end
    end

    // a first beat starts the dot product over
    assign sum = (first ? sgd_pkg::acc_word_t'(0) : psum_q) + beat_sum;

    always_ff @(posedge clk) begin
        if (rst) begin
            psum_q <= '0;
        end else begin
            psum_q <= sum;
        end
    end

    psum_known: assert property (
        @(posedge clk) disable iff (rst)
        !$isunknown(psum_q)
    ) else $error("partial sum carries X");

endmodule

// ==== delay_line.sv ====
//##########################################################################
// fixed-depth delay line
// shift register of DEPTH stages for any packed payload
//##########################################################################

`timescale 1ns/100ps

module delay_line #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 1
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t din,
    output payload_t dout
);

    // stage 0 takes din, the last stage drives dout
    payload_t stage_q [DEPTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= din;
            for (int i = 1; i < DEPTH; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign dout = stage_q[DEPTH-1];

endmodule

// ==== error_term.sv ====
//##########################################################################
// SGD stage 2, error term
// prediction minus label, latched on the last beat of each sample
//##########################################################################

`timescale 1ns/100ps

module error_term (
    input  logic               clk,
    input  logic               rst,
    input  sgd_pkg::acc_word_t sum,
    input  sgd_pkg::in_word_t  label,
    input  logic               last,
    output sgd_pkg::acc_word_t err
);

    // gradient factor of the squared loss, label sign-extended
    sgd_pkg::acc_word_t err_next;

    assign err_next = sum - sgd_pkg::acc_word_t'(label);

    // held for all the update beats of the sample
    always_ff @(posedge clk) begin
        if (rst) begin
            err <= '0;
        end else if (last) begin
            err <= err_next;
        end
    end

endmodule

// ==== weight_update.sv ====
//##########################################################################
// SGD stage 3, weight update
// w - ((mu * err * x) >>> shift) for every lane of the delayed beat
//##########################################################################

`timescale 1ns/100ps

`include "sgd_defines.svh"

module weight_update (
    input  sgd_pkg::beat_t     beat,
    input  sgd_pkg::acc_word_t err,
    input  sgd_pkg::in_word_t  mu,
    output sgd_pkg::result_t   result
);

    // wide enough to hold mu * err * x without loss
    localparam int PROD_W = 2 * `SGD_IN_W + `SGD_ACC_W;

    for (genvar i = 0; i < `SGD_LANES; i++) begin : g_lane
        logic signed [PROD_W-1:0] prod;
        logic signed [PROD_W-1:0] scaled;
        sgd_pkg::acc_word_t       step;

        // all operands signed, so each is sign-extended to PROD_W
        assign prod   = mu * err * beat.feat[i];
        assign scaled = prod >>> `SGD_SHIFT;

        // truncate to the accumulator width, the subtraction wraps
        assign step      = sgd_pkg::acc_word_t'(scaled);
        assign result[i] = sgd_pkg::acc_word_t'(beat.wgt[i]) - step;
    end

endmodule

// ==== sgd_accelerator.sv ====
//##########################################################################
// SGD accelerator top
// three-stage pipeline training a linear model one sample at a time
//##########################################################################

`timescale 1ns/100ps

`include "sgd_defines.svh"

module sgd_accelerator (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  sgd_pkg::beat_t     beat,
    input  sgd_pkg::in_word_t  label,
    input  sgd_pkg::in_word_t  mu,
    output sgd_pkg::result_t   weights_out,
    output logic               out_valid
);

    logic               first;
    logic               last;
    logic               busy;
    logic               busy_d;
    sgd_pkg::acc_word_t sum;
    sgd_pkg::acc_word_t err;
    sgd_pkg::in_word_t  label_d;
    sgd_pkg::beat_t     beat_d;
    sgd_pkg::result_t   result;

    sgd_controller u_ctrl (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .first (first),
        .last  (last),
        .busy  (busy)
    );

    // stage 1
    inner_product u_ip (
        .clk   (clk),
        .rst   (rst),
        .beat  (beat),
        .first (first),
        .sum   (sum)
    );

    // label sampled on the first beat, needed on the last
    delay_line #(
        .payload_t (sgd_pkg::in_word_t),
        .DEPTH     (`SGD_BEATS - 1)
    ) u_label_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (label),
        .dout (label_d)
    );

    // stage 2
    error_term u_err (
        .clk   (clk),
        .rst   (rst),
        .sum   (sum),
        .label (label_d),
        .last  (last),
        .err   (err)
    );

    // beats replay once err for their sample is ready
    delay_line #(
        .payload_t (sgd_pkg::beat_t),
        .DEPTH     (`SGD_BEATS)
    ) u_beat_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (beat),
        .dout (beat_d)
    );

    // valid travels alongside the replayed beats
    delay_line #(
        .payload_t (logic),
        .DEPTH     (`SGD_BEATS)
    ) u_valid_dly (
        .clk  (clk),
        .rst  (rst),
        .din  (busy),
        .dout (busy_d)
    );

    // stage 3
    weight_update u_upd (
        .beat   (beat_d),
        .err    (err),
        .mu     (mu),
        .result (result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            weights_out <= '0;
            out_valid   <= 1'b0;
        end else begin
            weights_out <= result;
            out_valid   <= busy_d;
        end
    end

    // each sample yields a full run of results at fixed latency
    sample_output_run: assert property (
        @(posedge clk) disable iff (rst)
        first |-> ##(`SGD_BEATS + 1) out_valid [*`SGD_BEATS]
    ) else $error("result run of a sample is late or short");

endmodule

// ==== tb_sgd_accelerator.sv ====
//##########################################################################
// SGD accelerator testbench
// random samples checked against a reference model of the SGD update
//##########################################################################

`timescale 1ns/100ps

`include "sgd_defines.svh"

module tb_sgd_accelerator;

    localparam int PERIOD        = 40;
    localparam int RESET_CYCLES  = 10;
    localparam int IDLE_CYCLES   = 12;
    localparam int N_B2B         = 6;
    localparam int N_GAP         = 6;
    localparam int MAX_GAP       = 6;
    localparam int N_MU0         = 2;
    localparam int N_EXT         = 3;
    localparam int TOTAL_SAMPLES = 1 + N_B2B + N_GAP + N_MU0 + N_EXT;
    // every driven beat, the gaps, a drain per test and some slack
    localparam int LIMIT_CYCLES  = RESET_CYCLES + IDLE_CYCLES + TOTAL_SAMPLES * `SGD_BEATS
                                 + N_GAP * MAX_GAP + 5 * (2 * `SGD_BEATS + 4) + 50;

    logic               clk;
    logic               rst;
    logic               start;
    sgd_pkg::beat_t     beat;
    sgd_pkg::in_word_t  label;
    sgd_pkg::in_word_t  mu;
    sgd_pkg::result_t   weights_out;
    logic               out_valid;

    integer             seed = 32'h0dd53a9c;
    int                 cyc = 0;
    int                 checks = 0;
    int                 errors = 0;
    int                 results_seen = 0;
    int                 run_len = 0;
    int                 max_run = 0;
    sgd_pkg::in_word_t  mu_cur = '0;

    // expected results and the cycle each one is due
    sgd_pkg::result_t   exp_res [$];
    int                 exp_cyc [$];

    sgd_accelerator uut (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .beat        (beat),
        .label       (label),
        .mu          (mu),
        .weights_out (weights_out),
        .out_valid   (out_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    initial begin
        #(LIMIT_CYCLES * PERIOD);
        $display("watchdog expired after %0d cycles, the run did not finish", LIMIT_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_value(input string what, input logic signed [63:0] got,
                               input logic signed [63:0] exp);
        checks = checks + 1;
        if (got !== exp) begin
            errors = errors + 1;
            $display("Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // wrap to the accumulator width and sign-extend back
    function automatic longint wrap_acc(input longint v);
        sgd_pkg::acc_word_t t;
        t = v[`SGD_ACC_W-1:0];
        return longint'(t);
    endfunction

    function automatic sgd_pkg::in_word_t rand_word(input bit extreme);
        int r;
        r = $random(seed);
        if (extreme) begin
            return r[0] ? sgd_pkg::in_word_t'(127) : sgd_pkg::in_word_t'(-128);
        end
        return r[`SGD_IN_W-1:0];
    endfunction

    // result check on the falling edge where outputs are stable
    always @(negedge clk) begin : monitor
        sgd_pkg::result_t exp_r;
        int               due;
        if (!rst) begin
            if (out_valid) begin
                run_len = run_len + 1;
                if (run_len > max_run) begin
                    max_run = run_len;
                end
                results_seen = results_seen + 1;
                if (exp_cyc.size() == 0) begin
                    errors = errors + 1;
                    $display("out_valid went high at %0t ns with no result expected", $time);
                end else begin
                    exp_r = exp_res.pop_front();
                    due   = exp_cyc.pop_front();
                    check_value("result cycle", cyc, due);
                    for (int i = 0; i < `SGD_LANES; i++) begin
                        check_value($sformatf("weight lane %0d", i), weights_out[i], exp_r[i]);
                    end
                end
            end else begin
                run_len = 0;
                if (exp_cyc.size() != 0 && cyc >= exp_cyc[0]) begin
                    errors = errors + 1;
                    $display("a result due in cycle %0d never appeared", exp_cyc[0]);
                    void'(exp_res.pop_front());
                    void'(exp_cyc.pop_front());
                end
            end
        end
    end

    task automatic idle_cycles(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk);
            start <= 1'b0;
            beat  <= {$random(seed), $random(seed)};
            label <= rand_word(1'b0);
        end
    endtask

    task automatic set_mu(input sgd_pkg::in_word_t v);
        @(posedge clk);
        mu_cur = v;
        mu    <= v;
    endtask

    // drives one sample and queues what the model expects from it
    task automatic send_sample(input bit extreme);
        sgd_pkg::beat_t    beats [`SGD_BEATS];
        int                pres [`SGD_BEATS];
        sgd_pkg::in_word_t lbl;
        sgd_pkg::result_t  r;
        longint            acc;
        longint            err_v;
        longint            prod;
        lbl = rand_word(extreme);
        for (int j = 0; j < `SGD_BEATS; j++) begin
            for (int i = 0; i < `SGD_LANES; i++) begin
                beats[j].feat[i] = rand_word(extreme);
                beats[j].wgt[i]  = rand_word(extreme);
            end
            @(posedge clk);
            start <= (j == 0);
            beat  <= beats[j];
            // only the first beat's label is used
            label <= (j == 0) ? lbl : rand_word(1'b0);
            pres[j] = cyc + 1;
        end
        acc = 0;
        for (int j = 0; j < `SGD_BEATS; j++) begin
            for (int i = 0; i < `SGD_LANES; i++) begin
                acc = wrap_acc(acc + longint'($signed(beats[j].feat[i]))
                                   * longint'($signed(beats[j].wgt[i])));
            end
        end
        // prediction minus label
        err_v = wrap_acc(acc - longint'($signed(lbl)));
        for (int j = 0; j < `SGD_BEATS; j++) begin
            for (int i = 0; i < `SGD_LANES; i++) begin
                prod = longint'(mu_cur) * err_v * longint'($signed(beats[j].feat[i]));
                r[i] = sgd_pkg::acc_word_t'(wrap_acc(longint'($signed(beats[j].wgt[i]))
                                                     - wrap_acc(prod >>> `SGD_SHIFT)));
            end
            exp_res.push_back(r);
            exp_cyc.push_back(pres[j] + `SGD_BEATS + 1);
        end
    endtask

    task automatic wait_drain();
        while (exp_cyc.size() != 0) begin
            @(posedge clk);
        end
        idle_cycles(2);
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin : main
        int errs_before;
        int seen_before;
        int gap;
        rst   <= 1'b1;
        start <= 1'b0;
        beat  <= '0;
        label <= '0;
        mu    <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // test 1 checks quiet outputs after reset
        errs_before = errors;
        for (int k = 0; k < IDLE_CYCLES; k++) begin
            @(negedge clk);
            check_value("out_valid when idle", out_valid, 0);
            for (int i = 0; i < `SGD_LANES; i++) begin
                check_value($sformatf("idle weight lane %0d", i), weights_out[i], 0);
            end
        end
        report_test("1 idle after reset", errs_before);

        // test 2 covers result count and latency of one sample
        errs_before = errors;
        set_mu(rand_word(1'b0));
        seen_before = results_seen;
        send_sample(1'b0);
        wait_drain();
        check_value("results of one sample", results_seen - seen_before, `SGD_BEATS);
        report_test("2 single sample", errs_before);

        // back-to-back samples keep out_valid high throughout
        errs_before = errors;
        set_mu(rand_word(1'b0));
        max_run = 0;
        for (int k = 0; k < N_B2B; k++) begin
            send_sample(1'b0);
        end
        wait_drain();
        check_value("out_valid run length", max_run, N_B2B * `SGD_BEATS);
        report_test("3 back-to-back samples", errs_before);

        // random idle gaps between samples
        errs_before = errors;
        set_mu(rand_word(1'b0));
        max_run = 0;
        for (int k = 0; k < N_GAP; k++) begin
            gap = 1 + int'({$random(seed)} % MAX_GAP);
            idle_cycles(gap);
            send_sample(1'b0);
        end
        wait_drain();
        check_value("longest out_valid run", max_run, `SGD_BEATS);
        report_test("4 samples with gaps", errs_before);

        // zero learning rate, then extreme operands
        errs_before = errors;
        set_mu('0);
        for (int k = 0; k < N_MU0; k++) begin
            send_sample(1'b0);
        end
        wait_drain();
        set_mu(sgd_pkg::in_word_t'(-128));
        for (int k = 0; k < N_EXT; k++) begin
            send_sample(1'b1);
        end
        wait_drain();
        report_test("5 zero mu and extreme operands", errs_before);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== filelist.f ====
+incdir+.
sgd_pkg.sv
sgd_controller.sv
inner_product.sv
delay_line.sv
error_term.sv
weight_update.sv
sgd_accelerator.sv
tb_sgd_accelerator.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, then look for failures in the log
cd "$(dirname "$0")" || exit 1

rm -f build.log sim.log

verilator --binary --timing --assert \
    -f filelist.f --top-module tb_sgd_accelerator -o tb_sim \
    > build.log 2>&1 \
    || { cat build.log; echo "build failed, see build.log"; exit 1; }

./obj_dir/tb_sim > sim.log 2>&1 \
    || { cat sim.log; echo "simulation aborted, see sim.log"; exit 1; }

cat sim.log

grep -q "TEST FAILED" sim.log \
    && { echo "failures reported in sim.log"; exit 1; } \
    || { echo "no failures reported"; exit 0; }
